//--- design/cache_pkg.sv
// --------------------------------------------------------------------
// cache geometry types and the request, response and line fill
// structs shared by the cache exerciser blocks
// --------------------------------------------------------------------

package cache_pkg;

  // address and data widths
  typedef logic [15:0] byte_addr_t;
  typedef logic [13:0] word_addr_t;
  typedef logic [11:0] line_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0]  data_byte_t;

  // cpu side, valid held until ready
  typedef struct packed {
    logic       valid;
    byte_addr_t addr;
  } cpu_req_t;

  // one-cycle response strobe with its byte
  typedef struct packed {
    logic       valid;
    data_byte_t data;
  } cpu_resp_t;

  // memory side, fill request is a single pulse
  typedef struct packed {
    logic       valid;
    line_addr_t line;
  } fill_req_t;

  // one strobe per word of the burst
  typedef struct packed {
    logic  valid;
    word_t word;
  } fill_data_t;

endpackage

//--- design/pattern_pkg.sv
// --------------------------------------------------------------------
// test data pattern, byte select and address jump table for the
// request generator, backing memory and response checker
// --------------------------------------------------------------------

package pattern_pkg;

  typedef logic [19:0] gen_count_t;

  // jump decision for the address after a given request count
  typedef struct packed {
    logic                  jump;
    cache_pkg::byte_addr_t target;
  } jump_t;

  // word contents are a scramble of the word address
  function automatic cache_pkg::word_t pattern_word(cache_pkg::word_addr_t a);
    return {~a[1:0], a[5:2], 2'b00, ~a[9:6], a[13:10],
            a[9:6], 2'b11, ~a[13:10], a[1:0], ~a[5:2]};
  endfunction

  // byte 0 is the most significant byte of the word
  function automatic cache_pkg::data_byte_t byte_of_word(cache_pkg::word_t w,
                                                         logic [1:0] offs);
    cache_pkg::data_byte_t b;
    case (offs)
      2'd0: b = w[31:24];
      2'd1: b = w[23:16];
      2'd2: b = w[15:8];
      default: b = w[7:0];
    endcase
    return b;
  endfunction

  function automatic jump_t jump_target(gen_count_t count, int lru_pattern);
    jump_t j;
    j.jump   = 1'b1;
    j.target = 16'h0000;
    case (count)
      20'h0003F, 20'h0007F, 20'h000BF, 20'h001FF: j.target = 16'h0000;
      20'h000FF, 20'h0013F, 20'h0017F, 20'h001BF: j.target = 16'h8000;
      default: j.jump = 1'b0;
    endcase
    // short LRU exercise right after the start
    if ((lru_pattern == 1 || lru_pattern == 2) && count >= 5 && count <= 10) begin
      j.jump = 1'b1;
      case (count)
        20'd5, 20'd7: j.target = 16'h0100;
        20'd6, 20'd8: j.target = 16'h0200;
        20'd9: j.target = (lru_pattern == 1) ? 16'h0100 : 16'h0500;
        default: j.target = 16'h0500;
      endcase
    end
    return j;
  endfunction

endpackage

//--- design/req_gen.sv
// --------------------------------------------------------------------
// request generator: waits out a holdoff after reset, then issues
// byte reads at a fixed spacing along a jumping address sequence
// --------------------------------------------------------------------

module req_gen #(
  parameter int HOLDOFF     = 80,
  parameter int DISTANCE    = 6,
  parameter int LRU_PATTERN = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ready,
  output cache_pkg::cpu_req_t cpu_req
);

  localparam int HOLD_BITS = $clog2(HOLDOFF + 2);
  localparam int DIST_BITS = $clog2(DISTANCE + 2);

  logic [HOLD_BITS-1:0]    holdoff_cnt;
  logic                    holding;
  logic [DIST_BITS-1:0]    dist_cnt;
  logic                    dist_done;
  logic                    issue;
  pattern_pkg::gen_count_t gen_count;
  pattern_pkg::jump_t      next_jump;
  logic                    jump_q;
  cache_pkg::byte_addr_t   target_q;

  assign holding   = holdoff_cnt != '0;
  assign dist_done = dist_cnt == DIST_BITS'(DISTANCE);
  assign issue     = ready && dist_done && !holding;
  assign next_jump = pattern_pkg::jump_target(gen_count, LRU_PATTERN);

  // --------------------------------------------------------------------
  // holdoff and spacing
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      holdoff_cnt <= HOLD_BITS'(HOLDOFF);
    end else if (holding) begin
      holdoff_cnt <= holdoff_cnt - 1'b1;
    end
  end

  // spacing only advances while the cache can take a request
  always_ff @(posedge clk) begin
    if (rst || holding) begin
      dist_cnt <= '0;
    end else if (ready) begin
      if (dist_done) begin
        dist_cnt <= '0;
      end else begin
        dist_cnt <= dist_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // address sequence
  // --------------------------------------------------------------------

  // jump decision for the count just issued, used by the next request
  always_ff @(posedge clk) begin
    if (rst) begin
      gen_count <= '0;
      jump_q    <= 1'b0;
    end else if (issue) begin
      gen_count <= gen_count + 1'b1;
      jump_q    <= next_jump.jump;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      target_q <= next_jump.target;
    end
  end

  // address starts one below zero so the first request reads 0x0000
  always_ff @(posedge clk) begin
    if (rst) begin
      cpu_req.valid <= 1'b0;
      cpu_req.addr  <= 16'hFFFF;
    end else begin
      if (ready) begin
        cpu_req.valid <= dist_done && !holding;
      end
      if (issue) begin
        if (jump_q) begin
          cpu_req.addr <= target_q;
        end else begin
          cpu_req.addr <= cpu_req.addr + 1'b1;
        end
      end
    end
  end

  // a stalled request must stay presented to the cache
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    cpu_req.valid && !ready |=> cpu_req.valid && $stable(cpu_req.addr))
    else $error("request changed while the cache was stalled");

endmodule

//--- design/byte_cache.sv
// --------------------------------------------------------------------
// two-way set-associative read-only byte cache with one LRU bit per
// set, filling 16-byte lines from the backing memory
// --------------------------------------------------------------------

module byte_cache #(
  parameter int SETS = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_pkg::cpu_req_t   cpu_req,
  output logic                  ready,
  output cache_pkg::cpu_resp_t  cpu_resp,
  output cache_pkg::fill_req_t  fill_req,
  input  cache_pkg::fill_data_t fill_data
);

  localparam int SET_BITS  = $clog2(SETS);
  localparam int LINE_BITS = $bits(cache_pkg::line_addr_t);
  localparam int TAG_BITS  = LINE_BITS - SET_BITS;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_RESPOND
  } state_t;

  typedef logic [SET_BITS-1:0] set_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  state_t                state;
  cache_pkg::word_t      data_mem [2][SETS*4];
  tag_t                  tag_mem [2][SETS];
  logic [SETS-1:0]       line_valid [2];
  logic [SETS-1:0]       lru;

  cache_pkg::line_addr_t req_line;
  set_t                  req_set;
  tag_t                  req_tag;
  logic [1:0]            way_hit;
  logic                  hit;
  logic                  accept;

  cache_pkg::byte_addr_t addr_q;
  logic                  way_q;
  set_t                  set_q;
  logic [1:0]            beat;
  logic                  fill_last;
  cache_pkg::word_t      resp_word;

  // --------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------

  assign req_line = cpu_req.addr[15:4];
  assign req_set  = req_line[SET_BITS-1:0];
  assign req_tag  = req_line[LINE_BITS-1:SET_BITS];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = line_valid[w][req_set] && (tag_mem[w][req_set] == req_tag);
    end
  end

  assign hit       = |way_hit;
  assign ready     = state != ST_FILL;
  assign accept    = cpu_req.valid && ready;
  assign set_q     = addr_q[4 +: SET_BITS];
  assign fill_last = fill_data.valid && (beat == 2'd3);

  // --------------------------------------------------------------------
  // control FSM
  // --------------------------------------------------------------------

  // lru points at the way to replace next
  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ST_IDLE;
      fill_req.valid <= 1'b0;
      beat           <= 2'd0;
      lru            <= '0;
      line_valid[0]  <= '0;
      line_valid[1]  <= '0;
    end else begin
      fill_req.valid <= 1'b0;
      case (state)
        ST_IDLE, ST_RESPOND: begin
          state <= ST_IDLE;
          if (accept) begin
            if (hit) begin
              lru[req_set] <= ~way_hit[1];
              state        <= ST_RESPOND;
            end else begin
              fill_req.valid <= 1'b1;
              fill_req.line  <= req_line;
              beat           <= 2'd0;
              state          <= ST_FILL;
            end
          end
        end
        ST_FILL: begin
          if (fill_data.valid) begin
            beat <= beat + 1'b1;
          end
          if (fill_last) begin
            line_valid[way_q][set_q] <= 1'b1;
            lru[set_q]               <= ~way_q;
            state                    <= ST_RESPOND;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // request capture and arrays
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= cpu_req.addr;
      way_q  <= hit ? way_hit[1] : lru[req_set];
    end
    if (state == ST_FILL && fill_data.valid) begin
      data_mem[way_q][{set_q, beat}] <= fill_data.word;
    end
    if (state == ST_FILL && fill_last) begin
      tag_mem[way_q][set_q] <= addr_q[4+SET_BITS +: TAG_BITS];
    end
  end

  // response is read from the array in the cycle after the hit or fill
  assign resp_word = data_mem[way_q][{set_q, addr_q[3:2]}];

  always_comb begin
    cpu_resp.valid = state == ST_RESPOND;
    cpu_resp.data  = pattern_pkg::byte_of_word(resp_word, addr_q[1:0]);
  end

  a_fill_in_fill: assert property (@(posedge clk) disable iff (rst)
    fill_data.valid |-> state == ST_FILL)
    else $error("fill word arrived outside a line fill");

  // a request offered during a fill stays offered until the cache takes it
  a_no_accept_stalled: assert property (@(posedge clk) disable iff (rst)
    cpu_req.valid && !ready |=> cpu_req.valid)
    else $error("request withdrawn while ready was low");

endmodule

//--- design/pattern_mem.sv
// --------------------------------------------------------------------
// backing memory model returning the pattern words of a line as a
// four-word burst after a fixed latency
// --------------------------------------------------------------------

module pattern_mem #(
  parameter int MEM_LATENCY = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_pkg::fill_req_t  fill_req,
  output cache_pkg::fill_data_t fill_data
);

  localparam int LAT_BITS = $clog2(MEM_LATENCY + 1);

  logic                  busy;
  logic [LAT_BITS-1:0]   lat_cnt;
  logic [1:0]            beat;
  logic                  beat_out;
  cache_pkg::line_addr_t line_q;

  assign beat_out = busy && (lat_cnt == '0);

  // latency countdown, then one word per cycle, offset 0 first
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      lat_cnt <= '0;
      beat    <= 2'd0;
    end else if (fill_req.valid) begin
      busy    <= 1'b1;
      lat_cnt <= LAT_BITS'(MEM_LATENCY - 1);
      beat    <= 2'd0;
    end else if (busy) begin
      if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end else begin
        beat <= beat + 1'b1;
        if (beat == 2'd3) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_req.valid) begin
      line_q <= fill_req.line;
    end
  end

  always_comb begin
    fill_data.valid = beat_out;
    fill_data.word  = pattern_pkg::pattern_word({line_q, beat});
  end

  // the cache waits for the whole burst before asking again
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    fill_req.valid |-> !busy)
    else $error("fill request while a burst is pending");

endmodule

//--- design/resp_check.sv
// --------------------------------------------------------------------
// response checker comparing each returned byte with the pattern and
// counting responses up to the test limit
// --------------------------------------------------------------------

module resp_check #(
  parameter int NUM_TESTS = 1000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  cache_pkg::cpu_req_t  cpu_req,
  input  logic                 ready,
  input  cache_pkg::cpu_resp_t cpu_resp,
  output logic                 test_ended,
  output logic                 test_error
);

  cache_pkg::byte_addr_t   addr_q;
  pattern_pkg::gen_count_t test_count;
  cache_pkg::word_t        expect_word;
  cache_pkg::data_byte_t   expect_byte;
  logic                    mismatch;

  // address of the request the next response belongs to
  always_ff @(posedge clk) begin
    if (cpu_req.valid && ready) begin
      addr_q <= cpu_req.addr;
    end
  end

  assign expect_word = pattern_pkg::pattern_word(addr_q[15:2]);
  assign expect_byte = pattern_pkg::byte_of_word(expect_word, addr_q[1:0]);
  assign mismatch    = cpu_resp.data != expect_byte;

  // responses after the end are ignored
  always_ff @(posedge clk) begin
    if (rst) begin
      test_count <= '0;
      test_ended <= 1'b0;
      test_error <= 1'b0;
    end else if (cpu_resp.valid && !test_ended) begin
      test_count <= test_count + 1'b1;
      if (test_count == pattern_pkg::gen_count_t'(NUM_TESTS - 1)) begin
        test_ended <= 1'b1;
      end
      if (mismatch) begin
        test_error <= 1'b1;
      end
    end
  end

endmodule

//--- design/cache_test_top.sv
// --------------------------------------------------------------------
// cache exerciser top: generator, cache, backing memory and checker
// --------------------------------------------------------------------

module cache_test_top #(
  parameter int HOLDOFF     = 80,
  parameter int DISTANCE    = 6,
  parameter int NUM_TESTS   = 1000,
  parameter int LRU_PATTERN = 0,
  parameter int SETS        = 64,
  parameter int MEM_LATENCY = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  output cache_pkg::cpu_req_t  cpu_req,
  output logic                 ready,
  output cache_pkg::cpu_resp_t cpu_resp,
  output logic                 test_ended,
  output logic                 test_error
);

  cache_pkg::fill_req_t  fill_req;
  cache_pkg::fill_data_t fill_data;

  req_gen #(
    .HOLDOFF     (HOLDOFF),
    .DISTANCE    (DISTANCE),
    .LRU_PATTERN (LRU_PATTERN)
  ) u_req_gen (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .cpu_req (cpu_req)
  );

  byte_cache #(
    .SETS (SETS)
  ) u_byte_cache (
    .clk       (clk),
    .rst       (rst),
    .cpu_req   (cpu_req),
    .ready     (ready),
    .cpu_resp  (cpu_resp),
    .fill_req  (fill_req),
    .fill_data (fill_data)
  );

  pattern_mem #(
    .MEM_LATENCY (MEM_LATENCY)
  ) u_pattern_mem (
    .clk       (clk),
    .rst       (rst),
    .fill_req  (fill_req),
    .fill_data (fill_data)
  );

  resp_check #(
    .NUM_TESTS (NUM_TESTS)
  ) u_resp_check (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .ready      (ready),
    .cpu_resp   (cpu_resp),
    .test_ended (test_ended),
    .test_error (test_error)
  );

endmodule

//--- sim/tb_cache_test.sv
// --------------------------------------------------------------------
// testbench for the cache exerciser: reference tag and LRU model with
// concurrent assertions on the top-level ports
// --------------------------------------------------------------------

module tb_cache_test;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HOLDOFF     = 80;
  localparam int DISTANCE    = 1;
  localparam int NUM_TESTS   = 300;
  localparam int LRU_PATTERN = 1;
  localparam int SETS        = 64;
  localparam int MEM_LATENCY = 3;
  localparam int MAX_CYCLES  = HOLDOFF + NUM_TESTS * (MEM_LATENCY + 7) + 100;

  // extra jumps at counts 5 to 10 for LRU patterns 1 and 2
  localparam cache_pkg::byte_addr_t LRU_JUMPS [2][6] = '{
    '{16'h0100, 16'h0200, 16'h0100, 16'h0200, 16'h0100, 16'h0500},
    '{16'h0100, 16'h0200, 16'h0100, 16'h0200, 16'h0500, 16'h0500}
  };

  logic                 clk;
  logic                 rst;
  cache_pkg::cpu_req_t  cpu_req;
  logic                 ready;
  cache_pkg::cpu_resp_t cpu_resp;
  logic                 test_ended;
  logic                 test_error;
  logic                 accept;

  // reference model state
  int unsigned           cycle = 0;
  int unsigned           since_rst;
  int unsigned           last_accept;
  logic                  seen_accept;
  logic [19:0]           req_count;
  cache_pkg::byte_addr_t exp_addr;
  int                    tag_ref [2][SETS];
  logic                  valid_ref [2][SETS];
  logic                  lru_ref [SETS];
  logic                  resp_pending;
  int unsigned           resp_due;
  cache_pkg::data_byte_t exp_data;
  int unsigned           resp_count;

  cache_test_top #(
    .HOLDOFF     (HOLDOFF),
    .DISTANCE    (DISTANCE),
    .NUM_TESTS   (NUM_TESTS),
    .LRU_PATTERN (LRU_PATTERN),
    .SETS        (SETS),
    .MEM_LATENCY (MEM_LATENCY)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .ready      (ready),
    .cpu_resp   (cpu_resp),
    .test_ended (test_ended),
    .test_error (test_error)
  );

  assign accept = cpu_req.valid && ready;

  always #4 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // address that follows the request with the given count
  function automatic cache_pkg::byte_addr_t next_address(logic [19:0] count,
                                                         cache_pkg::byte_addr_t addr);
    cache_pkg::byte_addr_t next;
    int                    idx;
    idx = int'(count) - 5;
    if ((LRU_PATTERN == 1 || LRU_PATTERN == 2) && idx >= 0 && idx <= 5) begin
      next = LRU_JUMPS[LRU_PATTERN - 1][idx];
    end else if (count == 20'h03F || count == 20'h07F || count == 20'h0BF ||
                 count == 20'h1FF) begin
      next = 16'h0000;
    end else if (count == 20'h0FF || count == 20'h13F || count == 20'h17F ||
                 count == 20'h1BF) begin
      next = 16'h8000;
    end else begin
      next = addr + 16'd1;
    end
    return next;
  endfunction

  // byte 0 sits in the top byte of the pattern word
  function automatic cache_pkg::data_byte_t expected_byte(cache_pkg::byte_addr_t addr);
    cache_pkg::word_t w;
    int               sh;
    w  = pattern_pkg::pattern_word(addr[15:2]);
    sh = 8 * (3 - int'(addr[1:0]));
    return w[sh +: 8];
  endfunction

  // --------------------------------------------------------------------
  // stimulus and end of run
  // --------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait (test_ended === 1'b1);
    repeat (2) @(posedge clk);
    if (test_error === 1'b0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      fail_run("test_error was high when the run ended");
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      fail_run("timeout: test_ended did not rise within the cycle limit");
    end
  end

  // --------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------

  always @(posedge clk) begin : ref_model
    int   set_idx;
    int   tag;
    logic hit0;
    logic hit1;
    logic victim;
    set_idx = int'(cpu_req.addr[15:4]) % SETS;
    tag     = int'(cpu_req.addr[15:4]) / SETS;
    hit0    = valid_ref[0][set_idx] && tag_ref[0][set_idx] == tag;
    hit1    = valid_ref[1][set_idx] && tag_ref[1][set_idx] == tag;
    victim  = lru_ref[set_idx];
    if (rst) begin
      since_rst    <= 0;
      seen_accept  <= 1'b0;
      req_count    <= '0;
      exp_addr     <= 16'h0000;
      resp_pending <= 1'b0;
      resp_count   <= 0;
      for (int s = 0; s < SETS; s++) begin
        valid_ref[0][s] <= 1'b0;
        valid_ref[1][s] <= 1'b0;
        lru_ref[s]      <= 1'b0;
      end
    end else begin
      since_rst <= since_rst + 1;
      if (cpu_resp.valid) begin
        resp_count   <= resp_count + 1;
        resp_pending <= 1'b0;
      end
      if (accept) begin
        seen_accept  <= 1'b1;
        last_accept  <= cycle;
        req_count    <= req_count + 1'b1;
        exp_addr     <= next_address(req_count, cpu_req.addr);
        exp_data     <= expected_byte(cpu_req.addr);
        resp_pending <= 1'b1;
        if (hit0 || hit1) begin
          // the other way becomes the replacement candidate
          lru_ref[set_idx] <= !hit1;
          resp_due         <= cycle + 1;
        end else begin
          tag_ref[victim][set_idx]   <= tag;
          valid_ref[victim][set_idx] <= 1'b1;
          lru_ref[set_idx]           <= !victim;
          resp_due                   <= cycle + MEM_LATENCY + 5;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  a_reset_values: assert property (@(posedge clk)
    rst |=> !cpu_req.valid && !cpu_resp.valid && !test_ended && !test_error && ready)
    else fail_run("outputs did not take their reset values");

  a_holdoff: assert property (@(posedge clk) disable iff (rst)
    cpu_req.valid |-> since_rst >= HOLDOFF + DISTANCE + 1)
    else fail_run("request raised before the holdoff time ran out");

  a_spacing: assert property (@(posedge clk) disable iff (rst)
    accept && seen_accept |-> cycle - last_accept >= DISTANCE + 1)
    else fail_run("accepted requests closer than the set spacing");

  a_addr: assert property (@(posedge clk) disable iff (rst)
    accept |-> cpu_req.addr == exp_addr)
    else fail_run($sformatf("mismatch cpu_req.addr: got %h expected %h",
                            $sampled(cpu_req.addr), $sampled(exp_addr)));

  a_resp_expected: assert property (@(posedge clk) disable iff (rst)
    cpu_resp.valid |-> resp_pending)
    else fail_run("response strobe without an outstanding request");

  // hit answers after 1 cycle and a miss after the fill
  a_resp_timing: assert property (@(posedge clk) disable iff (rst)
    resp_pending |-> cpu_resp.valid == (cycle == resp_due))
    else fail_run($sformatf("response timing wrong at cycle %0d, expected cycle %0d",
                            $sampled(cycle), $sampled(resp_due)));

  a_ready_level: assert property (@(posedge clk) disable iff (rst)
    resp_pending |-> ready == cpu_resp.valid)
    else fail_run("ready level wrong while a request was outstanding");

  a_resp_data: assert property (@(posedge clk) disable iff (rst)
    cpu_resp.valid |-> cpu_resp.data == exp_data)
    else fail_run($sformatf("mismatch cpu_resp.data: got %h expected %h",
                            $sampled(cpu_resp.data), $sampled(exp_data)));

  a_test_ended: assert property (@(posedge clk) disable iff (rst)
    test_ended == (resp_count >= NUM_TESTS))
    else fail_run($sformatf("mismatch test_ended: got %h expected %h",
                            $sampled(test_ended),
                            $sampled(resp_count) >= NUM_TESTS));

  a_no_error: assert property (@(posedge clk) disable iff (rst)
    !test_error)
    else fail_run("test_error went high");

endmodule

//--- cache_test_top.f
design/cache_pkg.sv
design/pattern_pkg.sv
design/req_gen.sv
design/byte_cache.sv
design/pattern_mem.sv
design/resp_check.sv
design/cache_test_top.sv
sim/tb_cache_test.sv

//--- run.sh
#!/bin/sh
# build and run the cache exerciser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_cache_test -f cache_test_top.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_cache_test 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
